// ==== logic/rx_dsp_pkg.sv ====
`default_nettype none

package rx_dsp_pkg;

    localparam int CHANNEL_WIDTH  = 4;
    localparam int FFE_LENGTH     = 3;
    localparam int CHAN_DEPTH     = 3;
    localparam int FFE_ACC_WIDTH  = 20;
    localparam int CHAN_ACC_WIDTH = 16;

    typedef logic signed [7:0]  code_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic        [3:0]  shift_t;
    typedef logic signed [9:0]  est_t;
    typedef logic signed [9:0]  thresh_t;
    typedef logic signed [7:0]  chan_tap_t;
    typedef logic signed [9:0]  est_code_t;
    typedef logic signed [10:0] error_t;

    // One decision per lane, lane 0 in bit 0
    typedef logic [CHANNEL_WIDTH-1:0] bit_word_t;

    // Lane 0 holds the earliest symbol of the word
    typedef struct packed {
        code_t [CHANNEL_WIDTH-1:0] lane;
    } code_word_t;

    typedef struct packed {
        error_t [CHANNEL_WIDTH-1:0] lane;
    } error_word_t;

    // Entry t is the code t symbols before the lane's own symbol
    typedef struct packed {
        code_t [FFE_LENGTH-1:0] tap;
    } lane_window_t;

    typedef struct packed {
        weight_t   [FFE_LENGTH-1:0] weights;
        shift_t                     ffe_shift;
        thresh_t                    thresh;
        chan_tap_t [CHAN_DEPTH-1:0] chan_taps;
        shift_t                     chan_shift;
    } dsp_cfg_t;

endpackage : rx_dsp_pkg

`default_nettype wire

// ==== logic/code_window.sv ====
`default_nettype none

module code_window (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rx_dsp_pkg::code_word_t adc_codes_i,
    output rx_dsp_pkg::lane_window_t [rx_dsp_pkg::CHANNEL_WIDTH-1:0] windows_o,
    output rx_dsp_pkg::code_word_t aligned_codes_o
);

    rx_dsp_pkg::code_word_t cur_q;
    rx_dsp_pkg::code_word_t prev_q;

    // Previous word in the low half, current word in the high half
    rx_dsp_pkg::code_t [2*rx_dsp_pkg::CHANNEL_WIDTH-1:0] history;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_q  <= '0;
            prev_q <= '0;
        end else begin
            cur_q  <= adc_codes_i;
            prev_q <= cur_q;
        end
    end

    assign history = {cur_q.lane, prev_q.lane};

    // Early lanes reach back into the previous word
    for (genvar j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin : g_lane
        for (genvar t = 0; t < rx_dsp_pkg::FFE_LENGTH; t++) begin : g_tap
            assign windows_o[j].tap[t] = history[rx_dsp_pkg::CHANNEL_WIDTH + j - t];
        end
    end

    // One word behind, lines up with the registered decisions
    assign aligned_codes_o = prev_q;

    a_codes_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(adc_codes_i)
    ) else $error("adc_codes_i carries unknown bits");

endmodule : code_window

`default_nettype wire

// ==== logic/ffe_slice_lane.sv ====
`default_nettype none

module ffe_slice_lane (
    input  logic                                             clk,
    input  logic                                             rst_n_i,
    input  rx_dsp_pkg::lane_window_t                         window_i,
    input  rx_dsp_pkg::weight_t [rx_dsp_pkg::FFE_LENGTH-1:0] weights_i,
    input  rx_dsp_pkg::shift_t                               ffe_shift_i,
    input  rx_dsp_pkg::thresh_t                              thresh_i,
    output rx_dsp_pkg::est_t                                 est_o,
    output logic                                             bit_o
);

    logic signed [rx_dsp_pkg::FFE_ACC_WIDTH-1:0] acc;
    logic signed [rx_dsp_pkg::FFE_ACC_WIDTH-1:0] prod;
    rx_dsp_pkg::est_t                            est_d;
    logic                                        bit_d;

    rx_dsp_pkg::est_t est_q;
    logic             bit_q;

    always_comb begin
        acc  = '0;
        prod = '0;
        for (int t = 0; t < rx_dsp_pkg::FFE_LENGTH; t++) begin
            prod = $signed(window_i.tap[t]) * $signed(weights_i[t]);
            acc  = acc + prod;
        end
        // Wraps to the low estimate bits after the shift
        est_d = rx_dsp_pkg::est_t'(acc >>> ffe_shift_i);
        bit_d = (est_d > thresh_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            est_q <= '0;
            bit_q <= 1'b0;
        end else begin
            est_q <= est_d;
            bit_q <= bit_d;
        end
    end

    assign est_o = est_q;
    assign bit_o = bit_q;

    a_bit_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(bit_o)
    ) else $error("slicer decision is unknown");

endmodule : ffe_slice_lane

`default_nettype wire

// ==== logic/channel_error_unit.sv ====
`default_nettype none

module channel_error_unit (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  rx_dsp_pkg::bit_word_t                               bits_i,
    input  rx_dsp_pkg::code_word_t                              aligned_codes_i,
    input  rx_dsp_pkg::chan_tap_t [rx_dsp_pkg::CHAN_DEPTH-1:0]  taps_i,
    input  rx_dsp_pkg::shift_t                                  chan_shift_i,
    output rx_dsp_pkg::error_word_t                             error_o
);

    rx_dsp_pkg::bit_word_t   prev_bits_q;
    rx_dsp_pkg::error_word_t err_d;
    rx_dsp_pkg::error_word_t err_q;

    // Older decisions in the low half, as in the code window
    logic [2*rx_dsp_pkg::CHANNEL_WIDTH-1:0] bit_history;

    assign bit_history = {bits_i, prev_bits_q};

    for (genvar j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin : g_lane
        logic signed [rx_dsp_pkg::CHAN_ACC_WIDTH-1:0] acc;
        logic signed [rx_dsp_pkg::CHAN_ACC_WIDTH-1:0] tap_ext;
        rx_dsp_pkg::est_code_t                        est_code;
        rx_dsp_pkg::error_t                           est_ext;
        rx_dsp_pkg::error_t                           code_ext;

        always_comb begin
            acc     = '0;
            tap_ext = '0;
            for (int t = 0; t < rx_dsp_pkg::CHAN_DEPTH; t++) begin
                tap_ext = taps_i[t];
                // Bit 1 is symbol +1, bit 0 is symbol -1
                if (bit_history[rx_dsp_pkg::CHANNEL_WIDTH + j - t]) begin
                    acc = acc + tap_ext;
                end else begin
                    acc = acc - tap_ext;
                end
            end
            est_code = rx_dsp_pkg::est_code_t'(acc >>> chan_shift_i);
        end

        // Sign extend both sides so the difference is exact
        assign est_ext  = est_code;
        assign code_ext = aligned_codes_i.lane[j];

        assign err_d.lane[j] = est_ext - code_ext;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_bits_q <= '0;
            err_q       <= '0;
        end else begin
            prev_bits_q <= bits_i;
            err_q       <= err_d;
        end
    end

    assign error_o = err_q;

    a_error_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(error_o)
    ) else $error("error word is unknown");

endmodule : channel_error_unit

`default_nettype wire

// ==== logic/rx_datapath_core.sv ====
`default_nettype none

module rx_datapath_core (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rx_dsp_pkg::code_word_t  adc_codes_i,
    input  rx_dsp_pkg::dsp_cfg_t    cfg_i,
    output rx_dsp_pkg::bit_word_t   bits_o,
    output rx_dsp_pkg::error_word_t error_o
);

    rx_dsp_pkg::lane_window_t [rx_dsp_pkg::CHANNEL_WIDTH-1:0] windows;
    rx_dsp_pkg::code_word_t                                   aligned_codes;
    rx_dsp_pkg::bit_word_t                                    lane_bits;

    code_window code_window_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .adc_codes_i     (adc_codes_i),
        .windows_o       (windows),
        .aligned_codes_o (aligned_codes)
    );

    // Weights and threshold are shared by all lanes
    for (genvar j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin : g_lane
        ffe_slice_lane ffe_slice_lane_inst (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .window_i    (windows[j]),
            .weights_i   (cfg_i.weights),
            .ffe_shift_i (cfg_i.ffe_shift),
            .thresh_i    (cfg_i.thresh),
            .est_o       (),
            .bit_o       (lane_bits[j])
        );
    end

    channel_error_unit channel_error_unit_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .bits_i          (lane_bits),
        .aligned_codes_i (aligned_codes),
        .taps_i          (cfg_i.chan_taps),
        .chan_shift_i    (cfg_i.chan_shift),
        .error_o         (error_o)
    );

    assign bits_o = lane_bits;

endmodule : rx_datapath_core

`default_nettype wire

// ==== verif/tb_rx_datapath.sv ====
`default_nettype none

module tb_rx_datapath;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    rx_dsp_pkg::code_word_t  adc_codes_i;
    rx_dsp_pkg::dsp_cfg_t    cfg_i;
    rx_dsp_pkg::bit_word_t   bits_o;
    rx_dsp_pkg::error_word_t error_o;

    // Model state and expected-value queues
    rx_dsp_pkg::dsp_cfg_t    cur_cfg;
    rx_dsp_pkg::code_word_t  word_prev;
    rx_dsp_pkg::code_word_t  word_earlier;
    rx_dsp_pkg::bit_word_t   bits_exp_q[$];
    rx_dsp_pkg::error_word_t err_exp_q[$];
    int                      bits_due_q[$];
    int                      err_due_q[$];
    int                      cycle = 0;
    int                      checks_done = 0;
    logic [15:0]             lfsr_state = 16'd10899;

    rx_datapath_core rx_datapath_core_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .adc_codes_i (adc_codes_i),
        .cfg_i       (cfg_i),
        .bits_o      (bits_o),
        .error_o     (error_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic rx_dsp_pkg::code_word_t random_word();
        rx_dsp_pkg::code_word_t w;
        for (int j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin
            w.lane[j] = rx_dsp_pkg::code_t'(take_bits(8));
        end
        return w;
    endfunction

    function automatic rx_dsp_pkg::dsp_cfg_t random_cfg();
        rx_dsp_pkg::dsp_cfg_t cfg;
        logic signed [6:0]    small_thresh;
        for (int t = 0; t < rx_dsp_pkg::FFE_LENGTH; t++) begin
            cfg.weights[t] = rx_dsp_pkg::weight_t'(take_bits(8));
        end
        cfg.ffe_shift = rx_dsp_pkg::shift_t'(take_bits(3));
        // Narrow threshold keeps both decisions frequent
        small_thresh = take_bits(7);
        cfg.thresh = small_thresh;
        for (int t = 0; t < rx_dsp_pkg::CHAN_DEPTH; t++) begin
            cfg.chan_taps[t] = rx_dsp_pkg::chan_tap_t'(take_bits(8));
        end
        cfg.chan_shift = rx_dsp_pkg::shift_t'(take_bits(3));
        return cfg;
    endfunction

    // Slicer decisions for one word, symbols before lane 0 come from prev
    function automatic rx_dsp_pkg::bit_word_t ffe_bits(input rx_dsp_pkg::code_word_t cur,
                                                       input rx_dsp_pkg::code_word_t prev,
                                                       input rx_dsp_pkg::dsp_cfg_t cfg);
        logic signed [rx_dsp_pkg::FFE_ACC_WIDTH-1:0] sum;
        rx_dsp_pkg::code_t                           sym;
        rx_dsp_pkg::est_t                            est;
        rx_dsp_pkg::bit_word_t                       bits;
        int                                          idx;
        for (int j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin
            sum = '0;
            for (int t = 0; t < rx_dsp_pkg::FFE_LENGTH; t++) begin
                idx = j - t;
                if (idx >= 0) begin
                    sym = cur.lane[idx];
                end else begin
                    sym = prev.lane[rx_dsp_pkg::CHANNEL_WIDTH + idx];
                end
                sum = sum + $signed(sym) * $signed(cfg.weights[t]);
            end
            est = rx_dsp_pkg::est_t'(sum >>> cfg.ffe_shift);
            bits[j] = ($signed(est) > $signed(cfg.thresh));
        end
        return bits;
    endfunction

    function automatic rx_dsp_pkg::error_word_t channel_errors(
        input rx_dsp_pkg::bit_word_t  cur_bits,
        input rx_dsp_pkg::bit_word_t  prev_bits,
        input rx_dsp_pkg::code_word_t codes,
        input rx_dsp_pkg::dsp_cfg_t   cfg
    );
        logic signed [rx_dsp_pkg::CHAN_ACC_WIDTH-1:0] sum;
        rx_dsp_pkg::est_code_t                        rebuilt;
        rx_dsp_pkg::error_word_t                      err;
        logic                                         b;
        int                                           idx;
        for (int j = 0; j < rx_dsp_pkg::CHANNEL_WIDTH; j++) begin
            sum = '0;
            for (int t = 0; t < rx_dsp_pkg::CHAN_DEPTH; t++) begin
                idx = j - t;
                b = (idx >= 0) ? cur_bits[idx] : prev_bits[rx_dsp_pkg::CHANNEL_WIDTH + idx];
                if (b) begin
                    sum = sum + $signed(cfg.chan_taps[t]);
                end else begin
                    sum = sum - $signed(cfg.chan_taps[t]);
                end
            end
            rebuilt = rx_dsp_pkg::est_code_t'(sum >>> cfg.chan_shift);
            err.lane[j] = rx_dsp_pkg::error_t'(rebuilt) - rx_dsp_pkg::error_t'(codes.lane[j]);
        end
        return err;
    endfunction

    function automatic void model_word(input  rx_dsp_pkg::code_word_t  cur,
                                       input  rx_dsp_pkg::code_word_t  prev,
                                       input  rx_dsp_pkg::code_word_t  earlier,
                                       input  rx_dsp_pkg::dsp_cfg_t    cfg,
                                       output rx_dsp_pkg::bit_word_t   exp_bits,
                                       output rx_dsp_pkg::error_word_t exp_err);
        rx_dsp_pkg::bit_word_t prev_bits;
        prev_bits = ffe_bits(prev, earlier, cfg);
        exp_bits  = ffe_bits(cur, prev, cfg);
        exp_err   = channel_errors(exp_bits, prev_bits, cur, cfg);
    endfunction

    task automatic check_bits(input rx_dsp_pkg::bit_word_t got,
                              input rx_dsp_pkg::bit_word_t exp);
        int bad_lane;
        bad_lane = -1;
        for (int j = rx_dsp_pkg::CHANNEL_WIDTH - 1; j >= 0; j--) begin
            if (got[j] !== exp[j]) begin
                bad_lane = j;
            end
        end
        checks_done++;
        if (bad_lane >= 0) begin
            $display("CHECK FAILED at time %0t: bits_o lane %0d is %b, expected %b",
                     $time, bad_lane, got[bad_lane], exp[bad_lane]);
            $display("Simulation failed");
            $fatal(1, "bits_o mismatch");
        end
    endtask

    task automatic check_error(input rx_dsp_pkg::error_word_t got,
                               input rx_dsp_pkg::error_word_t exp);
        int bad_lane;
        bad_lane = -1;
        for (int j = rx_dsp_pkg::CHANNEL_WIDTH - 1; j >= 0; j--) begin
            if (got.lane[j] !== exp.lane[j]) begin
                bad_lane = j;
            end
        end
        checks_done++;
        if (bad_lane >= 0) begin
            $display("CHECK FAILED at time %0t: error_o lane %0d is %0d, expected %0d",
                     $time, bad_lane, got.lane[bad_lane], exp.lane[bad_lane]);
            $display("Simulation failed");
            $fatal(1, "error_o mismatch");
        end
    endtask

    // Bits settle 3 cycle counts after the drive edge, errors 4
    task automatic drive_word(input rx_dsp_pkg::code_word_t w);
        rx_dsp_pkg::bit_word_t   exp_bits;
        rx_dsp_pkg::error_word_t exp_err;
        @(posedge clk);
        adc_codes_i <= w;
        cfg_i       <= cur_cfg;
        model_word(w, word_prev, word_earlier, cur_cfg, exp_bits, exp_err);
        bits_due_q.push_back(cycle + 3);
        bits_exp_q.push_back(exp_bits);
        err_due_q.push_back(cycle + 4);
        err_exp_q.push_back(exp_err);
        word_earlier = word_prev;
        word_prev    = w;
    endtask

    // Results still in flight mix old and new settings
    task automatic reconfigure(input rx_dsp_pkg::dsp_cfg_t cfg);
        cur_cfg = cfg;
        bits_due_q.delete();
        bits_exp_q.delete();
        err_due_q.delete();
        err_exp_q.delete();
    endtask

    task automatic run_words(input int count);
        for (int i = 0; i < count; i++) begin
            drive_word(random_word());
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n_i !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                $display("Timeout: reset was not released within 10 cycles");
                $display("Simulation failed");
                $fatal(1, "reset release timeout");
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (bits_due_q.size() > 0 || err_due_q.size() > 0) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                $display("Timeout: expected results were not drained within 20 cycles");
                $display("Simulation failed");
                $fatal(1, "drain timeout");
            end
        end
    endtask

    always @(negedge clk) begin
        if (bits_due_q.size() > 0 && bits_due_q[0] == cycle) begin
            void'(bits_due_q.pop_front());
            check_bits(bits_o, bits_exp_q.pop_front());
        end
        if (err_due_q.size() > 0 && err_due_q[0] == cycle) begin
            void'(err_due_q.pop_front());
            check_error(error_o, err_exp_q.pop_front());
        end
    end

    initial begin
        rx_dsp_pkg::dsp_cfg_t cfg;

        // Pass-through equalizer, weight 0 only
        cur_cfg = '0;
        cur_cfg.weights[0] = 8'sd1;
        cur_cfg.chan_taps[0] = 8'sd16;
        cur_cfg.chan_taps[1] = 8'sd8;
        cur_cfg.chan_taps[2] = -8'sd4;
        word_prev    = '0;
        word_earlier = '0;
        rst_n_i      = 1'b0;
        adc_codes_i  = '0;
        cfg_i        = cur_cfg;

        @(posedge clk);
        @(negedge clk);
        check_bits(bits_o, '0);
        check_error(error_o, '0);
        @(posedge clk);
        rst_n_i <= 1'b1;
        wait_reset_release();

        run_words(40);

        for (int k = 0; k < 3; k++) begin
            reconfigure(random_cfg());
            run_words(60);
        end

        // Extreme shifts wrap the low estimate bits
        cfg = random_cfg();
        cfg.ffe_shift  = 4'd0;
        cfg.chan_shift = 4'd15;
        reconfigure(cfg);
        run_words(40);
        cfg = random_cfg();
        cfg.ffe_shift  = 4'd15;
        cfg.chan_shift = 4'd0;
        reconfigure(cfg);
        run_words(40);

        wait_drain();
        if (checks_done > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("No results were compared");
            $display("Simulation failed");
            $fatal(1, "no checks performed");
        end
    end

endmodule : tb_rx_datapath

`default_nettype wire

// ==== compile.f ====
logic/rx_dsp_pkg.sv
logic/code_window.sv
logic/ffe_slice_lane.sv
logic/channel_error_unit.sv
logic/rx_datapath_core.sv
verif/tb_rx_datapath.sv

// ==== Bender.yml ====
package:
  name: rx_datapath

sources:
  - logic/rx_dsp_pkg.sv
  - logic/code_window.sv
  - logic/ffe_slice_lane.sv
  - logic/channel_error_unit.sv
  - logic/rx_datapath_core.sv
  - target: test
    files:
      - verif/tb_rx_datapath.sv
